// File: sources.f
+incdir+source
source/mera_pkg.sv
source/px_cycle.sv
source/px_bus_port.sv
source/bus_arbiter.sv
source/panel_loader.sv
source/bus_mem.sv
source/mera_core.sv
sim/mera_tb.sv

// File: sim/mera_tb.sv
/* MERA-400 core testbench
   Loads table programs through the panel, runs them, checks AC, IC and stop flags */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module mera_tb;

	localparam int n_tests = 5;
	localparam int max_words = 6;
	localparam int load_limit = 4 * `ALARM_CYCLES;	// Cycles allowed per panel write
	localparam int run_limit = 1000;	// Cycles allowed per program

	logic got;
	logic clo_;
	logic start;
	logic load_valid;
	logic [`ADDR_W-1:0] load_addr;
	logic [`WORD_W-1:0] load_data;
	logic load_ready;
	logic [`WORD_W-1:0] acc;
	logic [`ADDR_W-1:0] ic;
	logic halted;
	logic awaria;

	// Test table, filled once from seeded operands
	string test_name [n_tests];
	int n_words [n_tests];
	logic [`ADDR_W-1:0] word_ad [n_tests][max_words];
	logic [`WORD_W-1:0] word_dt [n_tests][max_words];
	logic [`WORD_W-1:0] exp_acc [n_tests];
	logic [`ADDR_W-1:0] exp_ic [n_tests];
	logic exp_halted [n_tests];
	logic exp_awaria [n_tests];

	integer seed;

	mera_core dut_i (.got, .clo_, .start, .load_valid, .load_addr, .load_data, .load_ready,
		.acc, .ic, .halted, .awaria);

	initial begin
		got = 1'b0;
		forever #2 got = ~got;	// 4 ns period
	end

	// Long form, opcode plus memory address
	function automatic mera_pkg::instr_word_t long_instr(input mera_pkg::opcode_t op,
		input logic [`ADDR_W-1:0] a);
		mera_pkg::instr_word_t iw;
		iw.long_f.op = op;
		iw.long_f.addr = a;
		return iw;
	endfunction

	// Short form, group opcode with sub-op and immediate
	function automatic mera_pkg::instr_word_t short_instr(input mera_pkg::short_op_t sop,
		input logic [7:0] imm);
		mera_pkg::instr_word_t iw;
		iw.short_f.op = mera_pkg::SHORT;
		iw.short_f.sop = sop;
		iw.short_f.imm = imm;
		return iw;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic compare_word(input string name, input string what,
		input logic [`WORD_W-1:0] exp, input logic [`WORD_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s %s: expected %h, actual %h", name, what, exp, act));
	endtask

	task automatic compare_addr(input string name, input string what,
		input logic [`ADDR_W-1:0] exp, input logic [`ADDR_W-1:0] act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s %s: expected %h, actual %h", name, what, exp, act));
	endtask

	task automatic compare_flag(input string name, input string what,
		input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s %s: expected %b, actual %b", name, what, exp, act));
	endtask

	task automatic add_word(input int t, input logic [`ADDR_W-1:0] a,
		input logic [`WORD_W-1:0] d);
		word_ad[t][n_words[t]] = a;
		word_dt[t][n_words[t]] = d;
		n_words[t] = n_words[t] + 1;
	endtask

	task automatic set_expect(input int t, input logic [`WORD_W-1:0] a,
		input logic [`ADDR_W-1:0] i, input logic h, input logic f);
		exp_acc[t] = a;
		exp_ic[t] = i;
		exp_halted[t] = h;
		exp_awaria[t] = f;
	endtask

	task automatic build_table();
		logic [`WORD_W-1:0] a, b, v1, c, d, e, f, sum;
		logic [7:0] imm;
		a = $random(seed);
		b = $random(seed);
		v1 = $random(seed);
		c = $random(seed);
		d = $random(seed);
		e = $random(seed);
		f = $random(seed);
		imm = $random(seed);
		for (int t = 0; t < n_tests; t++) n_words[t] = 0;
		// Load, add, halt; sum wraps at 16 bits
		test_name[0] = "load_add_halt";
		add_word(0, 12'h000, long_instr(mera_pkg::LW, 12'h020));
		add_word(0, 12'h001, long_instr(mera_pkg::AW, 12'h021));
		add_word(0, 12'h002, short_instr(mera_pkg::HLT, 8'h00));
		add_word(0, 12'h020, a);
		add_word(0, 12'h021, b);
		sum = a + b;
		set_expect(0, sum, 12'h003, 1'b1, 1'b0);
		// Store, then overwrite AC with word 0 before reloading
		if (v1 == long_instr(mera_pkg::LW, 12'h030)) v1 = v1 ^ 16'h0001;
		test_name[1] = "store_reload";
		add_word(1, 12'h000, long_instr(mera_pkg::LW, 12'h030));
		add_word(1, 12'h001, long_instr(mera_pkg::RW, 12'h040));
		add_word(1, 12'h002, long_instr(mera_pkg::LW, 12'h000));
		add_word(1, 12'h003, long_instr(mera_pkg::LW, 12'h040));
		add_word(1, 12'h004, short_instr(mera_pkg::HLT, 8'h00));
		add_word(1, 12'h030, v1);
		set_expect(1, v1, 12'h005, 1'b1, 1'b0);
		// Two IRB in a row, short view of the word
		test_name[2] = "short_irb";
		add_word(2, 12'h000, long_instr(mera_pkg::LW, 12'h050));
		add_word(2, 12'h001, short_instr(mera_pkg::IRB, imm));
		add_word(2, 12'h002, short_instr(mera_pkg::IRB, imm));
		add_word(2, 12'h003, short_instr(mera_pkg::HLT, 8'h00));
		add_word(2, 12'h050, c);
		sum = c + {8'h00, imm} + {8'h00, imm};
		set_expect(2, sum, 12'h004, 1'b1, 1'b0);
		// Second load hits no memory, AC keeps first value
		test_name[3] = "absent_load";
		add_word(3, 12'h000, long_instr(mera_pkg::LW, 12'h060));
		add_word(3, 12'h001, long_instr(mera_pkg::LW, 12'h900));
		add_word(3, 12'h002, short_instr(mera_pkg::HLT, 8'h00));
		add_word(3, 12'h060, d);
		set_expect(3, d, 12'h002, 1'b0, 1'b1);
		// Panel write to absent word first
		test_name[4] = "absent_panel_write";
		add_word(4, 12'h800, e ^ f);
		add_word(4, 12'h000, long_instr(mera_pkg::LW, 12'h020));
		add_word(4, 12'h001, long_instr(mera_pkg::AW, 12'h021));
		add_word(4, 12'h002, short_instr(mera_pkg::HLT, 8'h00));
		add_word(4, 12'h020, e);
		add_word(4, 12'h021, f);
		sum = e + f;
		set_expect(4, sum, 12'h003, 1'b1, 1'b0);
	endtask

	task automatic apply_reset();
		@(negedge got);
		clo_ = 1'b0;
		start = 1'b0;
		load_valid = 1'b0;
		repeat (8) @(negedge got);
		clo_ = 1'b1;
	endtask

	// One panel beat, then wait for the loader to free itself
	task automatic load_word(input int t, input int k);
		int waited;
		@(negedge got);
		load_addr = word_ad[t][k];
		load_data = word_dt[t][k];
		load_valid = 1'b1;
		@(negedge got);
		load_valid = 1'b0;
		waited = 0;
		while (!load_ready) begin
			if (waited == load_limit)
				abort_run($sformatf("timeout: panel never returned load_ready in test %s",
					test_name[t]));
			@(negedge got);
			waited++;
		end
	endtask

	task automatic run_program(input int t);
		int waited;
		@(negedge got);
		start = 1'b1;
		@(negedge got);
		start = 1'b0;
		waited = 0;
		while (!(halted || awaria)) begin
			if (waited == run_limit)
				abort_run($sformatf("timeout: test %s never reached halt or alarm",
					test_name[t]));
			@(negedge got);
			waited++;
		end
	endtask

	initial begin
		seed = 32'hc48c_e612;
		clo_ = 1'b0;
		start = 1'b0;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_table();
		for (int t = 0; t < n_tests; t++) begin
			apply_reset();
			@(negedge got);
			compare_word(test_name[t], "acc after reset", '0, acc);
			compare_addr(test_name[t], "ic after reset", '0, ic);
			compare_flag(test_name[t], "halted after reset", 1'b0, halted);
			compare_flag(test_name[t], "awaria after reset", 1'b0, awaria);
			compare_flag(test_name[t], "load_ready after reset", 1'b1, load_ready);
			for (int k = 0; k < n_words[t]; k++) load_word(t, k);
			run_program(t);
			compare_word(test_name[t], "acc", exp_acc[t], acc);
			compare_addr(test_name[t], "ic", exp_ic[t], ic);
			compare_flag(test_name[t], "halted", exp_halted[t], halted);
			compare_flag(test_name[t], "awaria", exp_awaria[t], awaria);
		end
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/mera_core.sv
/* MERA-400 core top
   Processor, panel loader, bus arbiter and memory on one system bus */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module mera_core (
	input logic got,
	input logic clo_,
	input logic start,
	input logic load_valid,
	input logic [`ADDR_W-1:0] load_addr,
	input logic [`WORD_W-1:0] load_data,
	output logic load_ready,
	output logic [`WORD_W-1:0] acc,
	output logic [`ADDR_W-1:0] ic,
	output logic halted,
	output logic awaria
);

	// Cycle control to bus port
	logic xfer, xfer_w, done, alarm;
	logic [`ADDR_W-1:0] xfer_ad;
	logic [`WORD_W-1:0] xfer_dt, data;

	// Master side of the bus
	logic zg_cpu, zg_pan, zw_cpu, zw_pan, w_cpu, w_pan;
	logic [`ADDR_W-1:0] ad_cpu, ad_pan;
	logic [`WORD_W-1:0] dt_cpu, dt_pan;

	// Shared bus to memory
	logic bus_req, bus_w, ok;
	logic [`ADDR_W-1:0] bus_ad;
	logic [`WORD_W-1:0] bus_dt, rd_dt;

	px_cycle cycle_i (.got, .clo_, .start, .done, .alarm, .rd_dt(data), .xfer, .xfer_ad,
		.xfer_w, .xfer_dt, .acc, .ic, .halted, .awaria);

	px_bus_port port_i (.got, .clo_, .xfer, .xfer_ad, .xfer_w, .xfer_dt, .zw(zw_cpu), .ok,
		.rd_dt, .zg(zg_cpu), .ad(ad_cpu), .w(w_cpu), .dt(dt_cpu), .done, .alarm, .data);

	panel_loader panel_i (.got, .clo_, .load_valid, .load_addr, .load_data, .zw(zw_pan), .ok,
		.load_ready, .zg(zg_pan), .ad(ad_pan), .w(w_pan), .dt(dt_pan));

	bus_arbiter #(.addr_w(`ADDR_W), .data_w(`WORD_W)) arb_i (.got, .clo_, .zg_cpu, .zg_pan,
		.ad_cpu, .ad_pan, .w_cpu, .w_pan, .dt_cpu, .dt_pan, .zw_cpu, .zw_pan, .bus_req,
		.bus_ad, .bus_w, .bus_dt);

	bus_mem mem_i (.got, .clo_, .bus_req, .bus_ad, .bus_w, .bus_dt, .ok, .rd_dt);

endmodule

`default_nettype wire

// File: source/bus_mem.sv
/* System bus memory module
   MEM_WORDS words, one OK per request, silent above its range */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module bus_mem (
	input logic got,
	input logic clo_,
	input logic bus_req,	// Granted request
	input logic [`ADDR_W-1:0] bus_ad,
	input logic bus_w,
	input logic [`WORD_W-1:0] bus_dt,
	output logic ok,
	output logic [`WORD_W-1:0] rd_dt
);

	logic [`WORD_W-1:0] mem [`MEM_WORDS];
	logic answered;	// Request already served
	logic hit;
	logic [mera_pkg::mem_aw-1:0] idx;

	assign idx = bus_ad[mera_pkg::mem_aw-1:0];
	assign hit = bus_req && !answered && (bus_ad < `ADDR_W'(`MEM_WORDS));

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			ok <= 1'b0;
			answered <= 1'b0;
		end else begin
			ok <= 1'b0;	// Single cycle pulse
			if (!bus_req) begin
				answered <= 1'b0;	// Ready for next request
			end else if (hit) begin
				ok <= 1'b1;
				answered <= 1'b1;
			end
		end
	end

	// Array access, read data lands with ok
	always_ff @(posedge got) begin
		if (hit) begin
			if (bus_w) mem[idx] <= bus_dt;
			else rd_dt <= mem[idx];
		end
	end

endmodule

`default_nettype wire

// File: source/panel_loader.sv
/* Front panel loader
   Second bus master, writes one loaded word per beat into memory */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module panel_loader (
	input logic got,
	input logic clo_,
	input logic load_valid,	// One beat starts a write
	input logic [`ADDR_W-1:0] load_addr,
	input logic [`WORD_W-1:0] load_data,
	input logic zw,
	input logic ok,
	output logic load_ready,
	output logic zg,
	output logic [`ADDR_W-1:0] ad,
	output logic w,
	output logic [`WORD_W-1:0] dt
);

	localparam int unsigned alarm_last = `ALARM_CYCLES - 1;

	logic [mera_pkg::alarm_w-1:0] cnt;

	assign load_ready = !zg;	// Idle while not requesting
	assign w = 1'b1;	// Panel only writes

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			zg <= 1'b0;
			cnt <= '0;
		end else if (!zg) begin
			if (load_valid) begin
				zg <= 1'b1;
				cnt <= '0;
			end
		end else if (zw && ok) begin
			zg <= 1'b0;
		end else if (cnt == alarm_last[mera_pkg::alarm_w-1:0]) begin
			zg <= 1'b0;	// Absent address, let go of the bus
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge got) begin
		if (!zg && load_valid) begin
			ad <= load_addr;
			dt <= load_data;
		end
	end

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
/* System bus arbiter
   Registered one-hot grant, panel first, held until request drops */

`timescale 1ns/10ps
`default_nettype none

module bus_arbiter #(
	parameter int addr_w = 12,
	parameter int data_w = 16
) (
	input logic got,
	input logic clo_,
	input logic zg_cpu,	// Processor request
	input logic zg_pan,	// Panel request
	input logic [addr_w-1:0] ad_cpu,
	input logic [addr_w-1:0] ad_pan,
	input logic w_cpu,
	input logic w_pan,
	input logic [data_w-1:0] dt_cpu,
	input logic [data_w-1:0] dt_pan,
	output logic zw_cpu,
	output logic zw_pan,
	output logic bus_req,
	output logic [addr_w-1:0] bus_ad,
	output logic bus_w,
	output logic [data_w-1:0] bus_dt
);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			zw_cpu <= 1'b0;
			zw_pan <= 1'b0;
		end else if (!zw_cpu && !zw_pan) begin
			if (zg_pan) zw_pan <= 1'b1;	// Panel has priority
			else if (zg_cpu) zw_cpu <= 1'b1;
		end else begin
			if (zw_pan && !zg_pan) zw_pan <= 1'b0;	// Release
			if (zw_cpu && !zg_cpu) zw_cpu <= 1'b0;
		end
	end

	// Granted master onto the bus
	assign bus_req = (zw_cpu && zg_cpu) || (zw_pan && zg_pan);
	assign bus_ad = zw_pan ? ad_pan : ad_cpu;
	assign bus_w = zw_pan ? w_pan : w_cpu;
	assign bus_dt = zw_pan ? dt_pan : dt_cpu;

endmodule

`default_nettype wire

// File: source/px_bus_port.sv
/* P-X system bus requester
   Latches one transfer, waits for OK, raises alarm on timeout */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module px_bus_port (
	input logic got,
	input logic clo_,
	input logic xfer,	// Transfer start from cycle control
	input logic [`ADDR_W-1:0] xfer_ad,
	input logic xfer_w,
	input logic [`WORD_W-1:0] xfer_dt,
	input logic zw,	// Bus granted
	input logic ok,	// Memory answer
	input logic [`WORD_W-1:0] rd_dt,
	output logic zg,	// Bus request
	output logic [`ADDR_W-1:0] ad,
	output logic w,
	output logic [`WORD_W-1:0] dt,
	output logic done,
	output logic alarm,
	output logic [`WORD_W-1:0] data	// Read data of last transfer
);

	localparam int unsigned alarm_last = `ALARM_CYCLES - 1;

	logic [mera_pkg::alarm_w-1:0] cnt;	// Cycles since request
	logic answer;

	assign answer = zg && zw && ok;	// OK counts only with our grant

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			zg <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			alarm <= 1'b0;
		end else begin
			done <= 1'b0;
			alarm <= 1'b0;
			if (!zg) begin
				if (xfer) begin
					zg <= 1'b1;
					cnt <= '0;
				end
			end else if (answer) begin
				zg <= 1'b0;
				done <= 1'b1;
			end else if (cnt == alarm_last[mera_pkg::alarm_w-1:0]) begin
				zg <= 1'b0;	// No module answered
				alarm <= 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge got) begin
		if (!zg && xfer) begin
			ad <= xfer_ad;
			w <= xfer_w;
			dt <= xfer_dt;
		end
		if (answer) data <= rd_dt;	// Valid with done
	end

endmodule

`default_nettype wire

// File: source/px_cycle.sv
/* P-X instruction cycle control
   Steps fetch, decode, argument and execute states; holds AC and IC */

`timescale 1ns/10ps
`default_nettype none

`include "px_cfg.svh"

module px_cycle (
	input logic got,
	input logic clo_,
	input logic start,	// Leave STOP
	input logic done,	// Bus transfer finished
	input logic alarm,	// Bus transfer timed out
	input logic [`WORD_W-1:0] rd_dt,	// Data from last transfer
	output logic xfer,	// Start bus transfer
	output logic [`ADDR_W-1:0] xfer_ad,
	output logic xfer_w,
	output logic [`WORD_W-1:0] xfer_dt,
	output logic [`WORD_W-1:0] acc,
	output logic [`ADDR_W-1:0] ic,
	output logic halted,
	output logic awaria
);

	mera_pkg::cycle_state_t state;
	mera_pkg::instr_word_t ir;	// Instruction register
	logic long_form;
	logic is_hlt;
	logic is_irb;

	// Opcode picks the view of the word
	assign long_form = (ir.long_f.op == mera_pkg::LW) ||
		(ir.long_f.op == mera_pkg::RW) ||
		(ir.long_f.op == mera_pkg::AW);
	assign is_hlt = (ir.short_f.op == mera_pkg::SHORT) && (ir.short_f.sop == mera_pkg::HLT);
	assign is_irb = (ir.short_f.op == mera_pkg::SHORT) && (ir.short_f.sop == mera_pkg::IRB);

	assign halted = (state == mera_pkg::HALT);
	assign awaria = (state == mera_pkg::ALARM);

	always_ff @(posedge got or negedge clo_) begin
		if (!clo_) begin
			state <= mera_pkg::STOP;
			xfer <= 1'b0;
			acc <= '0;
			ic <= '0;
		end else begin
			xfer <= 1'b0;	// One cycle pulse
			unique case (state)
				mera_pkg::STOP: begin
					if (start) begin
						state <= mera_pkg::P1;
						xfer <= 1'b1;	// First fetch
					end
				end
				mera_pkg::P1: begin
					if (alarm) begin
						state <= mera_pkg::ALARM;
					end else if (done) begin
						state <= mera_pkg::P4;
						ic <= ic + 1'b1;	// Wraps at ADDR_W
					end
				end
				mera_pkg::P4: begin
					if (long_form) begin
						state <= mera_pkg::WM;
						xfer <= 1'b1;	// Argument access
					end else begin
						state <= mera_pkg::WE;
					end
				end
				mera_pkg::WM: begin
					if (alarm) state <= mera_pkg::ALARM;
					else if (done) state <= mera_pkg::WE;
				end
				mera_pkg::WE: begin
					// rd_dt still holds the WM read
					if (ir.long_f.op == mera_pkg::LW) acc <= rd_dt;
					else if (ir.long_f.op == mera_pkg::AW) acc <= acc + rd_dt;
					else if (is_irb) acc <= acc + {{(`WORD_W - 8){1'b0}}, ir.short_f.imm};
					if (is_hlt) begin
						state <= mera_pkg::HALT;
					end else begin
						state <= mera_pkg::P1;
						xfer <= 1'b1;	// Next fetch
					end
				end
				mera_pkg::HALT, mera_pkg::ALARM: ;	// Held until reset
				default: state <= mera_pkg::ALARM;
			endcase
		end
	end

	// Instruction and transfer payload
	always_ff @(posedge got) begin
		if (state == mera_pkg::P1 && done) ir <= rd_dt;
		if ((state == mera_pkg::STOP && start) || state == mera_pkg::WE) begin
			xfer_ad <= ic;	// Fetch address
			xfer_w <= 1'b0;
		end
		if (state == mera_pkg::P4) begin
			xfer_ad <= ir.long_f.addr;
			xfer_w <= (ir.long_f.op == mera_pkg::RW);	// Store writes
			xfer_dt <= acc;
		end
	end

endmodule

`default_nettype wire

// File: source/mera_pkg.sv
/* MERA-400 shared types
   Cycle states, opcodes and the two-view instruction word */

`default_nettype none

`include "px_cfg.svh"

package mera_pkg;

	// Timeout counter width, shared by both bus masters
	localparam int alarm_w = $clog2(`ALARM_CYCLES + 1);
	// Memory index width
	localparam int mem_aw = $clog2(`MEM_WORDS);

	typedef enum logic [2:0] {
		STOP,	// Idle, waiting for start
		P1,	// Instruction fetch
		P4,	// Decode
		WM,	// Long form memory access
		WE,	// Execute
		HALT,	// Normal stop
		ALARM	// Stopped on bus failure
	} cycle_state_t;

	typedef enum logic [3:0] {
		LW = 4'h1,	// Load accumulator
		RW = 4'h2,	// Store accumulator
		AW = 4'h3,	// Add to accumulator
		SHORT = 4'hf	// Short form group
	} opcode_t;

	typedef enum logic [3:0] {
		IRB = 4'h0,	// Increment by immediate
		HLT = 4'h1	// Halt
	} short_op_t;

	typedef union packed {
		struct packed {
			opcode_t op;
			logic [`ADDR_W-1:0] addr;	// Memory argument
		} long_f;
		struct packed {
			opcode_t op;
			short_op_t sop;
			logic [7:0] imm;	// Unsigned immediate
		} short_f;
	} instr_word_t;

endpackage

`default_nettype wire

// File: source/px_cfg.svh
/* P-X configuration
   Word and bus widths, memory size and bus alarm timeout */

`ifndef PX_CFG_SVH
`define PX_CFG_SVH

// Data word width
`define WORD_W 16

// System bus address width
`define ADDR_W 12

// Words physically present, higher addresses get no OK
`define MEM_WORDS 256

// Cycles a master waits for OK before alarm
`define ALARM_CYCLES 32

`endif
